/* flist.f */
design/cpu_bus_pkg.sv
design/address_decoder.sv
design/bus_arbiter.sv
design/cpu_ram.sv
design/flash_reader.sv
design/io_regs.sv
design/cpu_bus_top.sv
bench/cpu_bus_tb.sv

/* Bender.yml */
package:
  name: cpu_bus

sources:
  - design/cpu_bus_pkg.sv
  - design/address_decoder.sv
  - design/bus_arbiter.sv
  - design/cpu_ram.sv
  - design/flash_reader.sv
  - design/io_regs.sv
  - design/cpu_bus_top.sv
  - target: simulation
    files:
      - bench/cpu_bus_tb.sv

/* bench/cpu_bus_tb.sv */
/*
 * Directed testbench for the CPU memory bus with registered read data.
 * Runs reset, RAM, flash, I/O, unmapped and random mixed accesses
 * against a small reference model and prints one line per test.
 */
module cpu_bus_tb
    import cpu_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAM_WORDS      = 1024;
    localparam int NUM_RANDOM     = 200;
    // ram, flash, io, unmapped, then the random mix
    localparam int NUM_ACCESSES   = 15 + 6 + 10 + 10 + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = 20 * NUM_ACCESSES;
    localparam addr_t FLASH_END   = 16'hBFFF;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cpu_valid;
    addr_t      cpu_addr;
    data_t      cpu_wdata;
    strb_t      cpu_wstrb;
    logic [1:0] pad;
    logic       cpu_ready;
    data_t      cpu_rdata;

    // reference model state
    data_t       ram_model [RAM_WORDS];
    bit          ram_known [RAM_WORDS];
    data_t       status_model = '0;
    logic [1:0]  pad_model = 2'b00;

    logic [31:0] rng_state = 32'd61;
    int          error_count = 0;
    int          errors_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    string       current_test = "reset";

    cpu_bus_top #(
        .RAM_WORDS(RAM_WORDS),
        .FLASH_WAIT(3),
        .READ_DATA_REG(1'b1)
    ) i_dut (
        .clk, .rst_n, .cpu_valid, .cpu_addr, .cpu_wdata, .cpu_wstrb,
        .pad, .cpu_ready, .cpu_rdata
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, test %s hung", cycle_count, current_test);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // RAM fills the whole window below flash
    function automatic region_e region_of(input addr_t addr);
        if (addr < FLASH_BASE) begin
            return REGION_RAM;
        end else if (addr <= FLASH_END) begin
            return REGION_FLASH;
        end else if (addr == STATUS_ADDR) begin
            return REGION_STATUS;
        end else if (addr == PAD_ADDR) begin
            return REGION_PAD;
        end
        return REGION_NONE;
    endfunction

    function automatic int ram_index(input addr_t addr);
        return int'(addr[15:2]) % RAM_WORDS;
    endfunction

    function automatic data_t expected_read(input addr_t addr);
        addr_t offset;
        offset = addr - FLASH_BASE;
        case (region_of(addr))
            REGION_RAM:    return ram_model[ram_index(addr)];
            REGION_FLASH:  return {16'hF1A5, offset >> 2};
            REGION_STATUS: return status_model;
            REGION_PAD:    return {30'b0, pad_model};
            default:       return '0;
        endcase
    endfunction

    function automatic void model_write(input addr_t addr, input data_t data,
                                        input strb_t strb);
        int idx;
        idx = ram_index(addr);
        if (region_of(addr) == REGION_RAM) begin
            ram_model[idx] = merge_bytes(ram_model[idx], data, strb);
            ram_known[idx] = 1'b1;
        end else if (region_of(addr) == REGION_STATUS) begin
            status_model = merge_bytes(status_model, data, strb);
        end
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    // one handshake with ready low before and after its single pulse
    task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                              output data_t rdata);
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        cpu_wstrb <= wstrb;
        @(negedge clk);
        check_ready("cpu_ready", cpu_ready, 1'b0);
        while (cpu_ready !== 1'b1) begin
            @(negedge clk);
        end
        rdata = cpu_rdata;
        @(posedge clk);
        cpu_valid <= 1'b0;
        cpu_wstrb <= '0;
        @(negedge clk);
        check_ready("cpu_ready", cpu_ready, 1'b0);
    endtask

    task automatic write_word(input addr_t addr, input data_t data, input strb_t strb);
        data_t rdata;
        bus_access(addr, data, strb, rdata);
        model_write(addr, data, strb);
    endtask

    task automatic checked_read(input addr_t addr);
        data_t rdata;
        bus_access(addr, '0, 4'h0, rdata);
        check_data($sformatf("cpu_rdata@%h", addr), rdata, expected_read(addr));
    endtask

    task automatic set_pad(input logic [1:0] value);
        @(posedge clk);
        pad <= value;
        // two synchronizer flops plus margin
        repeat (3) @(posedge clk);
        pad_model = value;
    endtask

    task automatic start_test(input string name);
        current_test = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %-10s ok", current_test);
        end else begin
            tests_failed++;
            $display("test %-10s failed, %0d errors", current_test,
                     error_count - errors_at_start);
        end
    endtask

    task automatic reset_idle_test();
        start_test("reset");
        repeat (5) begin
            @(negedge clk);
            check_ready("cpu_ready", cpu_ready, 1'b0);
            check_data("cpu_rdata", cpu_rdata, '0);
        end
        finish_test();
    endtask

    task automatic ram_test();
        addr_t addr;
        start_test("ram");
        write_word(16'h0014, 32'h1122_3344, 4'hF);
        write_word(16'h0014, 32'hAABB_CCDD, 4'b0101);
        checked_read(16'h0014);
        for (int i = 0; i < 3; i++) begin
            addr = addr_t'((next_random() % RAM_WORDS) * 4);
            write_word(addr, next_random(), 4'hF);
            write_word(addr, next_random(), strb_t'(next_random()));
            checked_read(addr);
        end
        // word RAM_WORDS + 7 lands on word 7
        write_word(addr_t'((RAM_WORDS + 7) * 4), 32'hCAFE_0007, 4'hF);
        checked_read(16'h001C);
        checked_read(addr_t'((RAM_WORDS + 7) * 4));
        finish_test();
    endtask

    task automatic flash_test();
        logic [11:0] indices [4] = '{12'h000, 12'h001, 12'h123, 12'hFFF};
        start_test("flash");
        foreach (indices[i]) begin
            checked_read(FLASH_BASE + addr_t'({indices[i], 2'b00}));
        end
        write_word(FLASH_BASE + 16'h0008, 32'hDEAD_BEEF, 4'hF);
        checked_read(FLASH_BASE + 16'h0008);
        finish_test();
    endtask

    task automatic io_test();
        start_test("io");
        checked_read(STATUS_ADDR);
        write_word(STATUS_ADDR, 32'h1234_5678, 4'hF);
        write_word(STATUS_ADDR, 32'hAAAA_BBBB, 4'b0011);
        checked_read(STATUS_ADDR);
        write_word(STATUS_ADDR, 32'hCCDD_EEFF, 4'b1100);
        checked_read(STATUS_ADDR);
        set_pad(2'b10);
        checked_read(PAD_ADDR);
        write_word(PAD_ADDR, 32'hFFFF_FFFF, 4'hF);
        checked_read(PAD_ADDR);
        set_pad(2'b01);
        checked_read(PAD_ADDR);
        finish_test();
    endtask

    task automatic unmapped_test();
        addr_t none_addrs [4] = '{16'hC008, 16'hC002, 16'hD000, 16'hFFFC};
        data_t rdata;
        start_test("unmapped");
        foreach (none_addrs[i]) begin
            bus_access(none_addrs[i], next_random(), 4'hF, rdata);
            check_data("cpu_rdata", rdata, '0);
            checked_read(none_addrs[i]);
        end
        // earlier contents must survive
        checked_read(STATUS_ADDR);
        checked_read(16'h0014);
        finish_test();
    endtask

    task automatic random_mix_test();
        logic [31:0] r;
        int          pick;
        int          word;
        addr_t       addr;
        data_t       wdata;
        strb_t       strb;
        start_test("random");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            pick  = int'(next_random() % 5);
            r     = next_random();
            wdata = next_random();
            strb  = r[31] ? r[3:0] : 4'h0;
            case (pick)
                0: begin
                    word = int'(r[7:4]) + int'(r[9:8]) * RAM_WORDS;
                    if (!ram_known[word % RAM_WORDS]) begin
                        strb = 4'hF;
                    end
                    addr = addr_t'(word * 4);
                end
                1: addr = FLASH_BASE + addr_t'({r[15:4], 2'b00});
                2: addr = STATUS_ADDR;
                3: addr = PAD_ADDR;
                default: addr = 16'hC008 + addr_t'({r[11:4], 2'b00});
            endcase
            if (strb != 4'h0) begin
                write_word(addr, wdata, strb);
            end else begin
                checked_read(addr);
            end
        end
        finish_test();
    endtask

    initial begin
        rst_n     = 1'b0;
        cpu_valid = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        pad       = 2'b00;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        reset_idle_test();
        ram_test();
        flash_test();
        io_test();
        unmapped_test();
        random_mix_test();

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* design/cpu_bus_top.sv */
/*
 * Top level of the CPU memory bus.
 * Sets the bus parameters and wires the decoder, the arbiter,
 * the RAM, the flash reader and the I/O registers together.
 */
module cpu_bus_top
    import cpu_bus_pkg::*;
#(
    parameter int RAM_WORDS     = 1024,
    parameter int FLASH_WAIT    = 3,
    parameter bit READ_DATA_REG = 1'b0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cpu_valid,
    input  addr_t      cpu_addr,
    input  data_t      cpu_wdata,
    input  strb_t      cpu_wstrb,
    input  logic [1:0] pad,
    output logic       cpu_ready,
    output data_t      cpu_rdata
);
    logic        ram_sel, ram_we, flash_sel, status_sel, pad_sel, none_sel;
    logic        ram_cs, ram_we_q;
    logic [13:0] ram_addr;
    data_t       ram_wdata, ram_rdata;
    strb_t       ram_wstrb;
    logic        flash_req, flash_done;
    logic [11:0] flash_index;
    data_t       flash_rdata;
    logic        io_wr;
    strb_t       io_wstrb;
    data_t       io_wdata, io_rdata;

    address_decoder #(
        .RAM_WORDS(RAM_WORDS)
    ) i_decoder (
        .cpu_valid, .cpu_addr, .cpu_wstrb,
        .ram_sel, .ram_we, .flash_sel, .status_sel, .pad_sel, .none_sel
    );

    bus_arbiter #(
        .READ_DATA_REG(READ_DATA_REG)
    ) i_arbiter (
        .clk, .rst_n, .cpu_addr, .cpu_wdata, .cpu_wstrb,
        .ram_sel, .ram_we, .flash_sel, .status_sel, .pad_sel, .none_sel,
        .ram_rdata, .flash_rdata, .flash_done, .io_rdata,
        .ram_cs, .ram_we_q, .ram_addr, .ram_wdata, .ram_wstrb,
        .flash_req, .flash_index, .io_wr, .io_wstrb, .io_wdata,
        .cpu_ready, .cpu_rdata
    );

    cpu_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) i_ram (
        .clk, .cs(ram_cs), .we(ram_we_q), .addr(ram_addr),
        .wdata(ram_wdata), .wstrb(ram_wstrb), .rdata(ram_rdata)
    );

    flash_reader #(
        .FLASH_WAIT(FLASH_WAIT)
    ) i_flash (
        .clk, .rst_n, .req(flash_req), .index(flash_index),
        .rdata(flash_rdata), .done(flash_done)
    );

    // I/O selects come straight from the decoder
    io_regs i_io (
        .clk, .rst_n, .status_sel, .pad_sel, .wr(io_wr),
        .wstrb(io_wstrb), .wdata(io_wdata), .pad, .rdata(io_rdata)
    );

endmodule

/* design/io_regs.sv */
/*
 * Small I/O block on the CPU bus.
 * Holds a byte-writable status scratch register and samples the
 * two-bit pad input through a two-flop synchronizer.
 */
module io_regs
    import cpu_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       status_sel,
    input  logic       pad_sel,
    input  logic       wr,
    input  strb_t      wstrb,
    input  data_t      wdata,
    input  logic [1:0] pad,
    output data_t      rdata
);
    data_t      status_q;
    logic [1:0] pad_meta;
    logic [1:0] pad_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= '0;
        end else if (wr && status_sel) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    status_q[8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // pad lines are asynchronous to clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pad_meta <= '0;
            pad_sync <= '0;
        end else begin
            pad_meta <= pad;
            pad_sync <= pad_meta;
        end
    end

    always_comb begin
        if (status_sel) begin
            rdata = status_q;
        end else if (pad_sel) begin
            rdata = {30'b0, pad_sync};
        end else begin
            rdata = '0;
        end
    end

endmodule

/* design/flash_reader.sv */
/*
 * Read-only flash model with a fixed number of wait states.
 * A request starts the wait counter; on expiry the word is latched
 * and done pulses once. A new read needs req to drop first.
 */
module flash_reader
    import cpu_bus_pkg::*;
#(
    parameter int FLASH_WAIT = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic [11:0] index,
    output data_t       rdata,
    output logic        done
);
    localparam int CNT_W = $clog2(FLASH_WAIT + 2);

    logic [CNT_W-1:0] wait_cnt;
    logic             counting;
    logic             armed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            counting <= 1'b0;
            armed    <= 1'b1;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;

            // rearm once the arbiter has let go of the request
            if (!req && !counting) begin
                armed <= 1'b1;
            end

            if (counting) begin
                if (wait_cnt == '0) begin
                    counting <= 1'b0;
                    done     <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end else if (req && armed) begin
                counting <= 1'b1;
                armed    <= 1'b0;
                wait_cnt <= CNT_W'(FLASH_WAIT);
            end
        end
    end

    // word captured on the same edge that raises done
    always_ff @(posedge clk) begin
        if (counting && wait_cnt == '0) begin
            rdata <= flash_word(index);
        end
    end

endmodule

/* design/cpu_ram.sv */
/*
 * On-chip word RAM for the CPU bus.
 * Byte-strobed writes on the clock edge, read port is asynchronous.
 * Word addresses wrap modulo RAM_WORDS.
 */
module cpu_ram
    import cpu_bus_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic        clk,
    input  logic        cs,
    input  logic        we,
    input  logic [13:0] addr,
    input  data_t       wdata,
    input  strb_t       wstrb,
    output data_t       rdata
);
    localparam int IDX_W = $clog2(RAM_WORDS);

    data_t             mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;

    // aliasing above the physical size
    assign idx = IDX_W'(addr % RAM_WORDS);

    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = mem[idx];

endmodule

/* design/bus_arbiter.sv */
/*
 * Bus arbiter: forwards the current access to RAM, flash or I/O,
 * muxes the read data back and raises one cpu_ready pulse per access.
 * READ_DATA_REG adds a register stage on ready and read data.
 */
module bus_arbiter
    import cpu_bus_pkg::*;
#(
    parameter bit READ_DATA_REG = 1'b0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  addr_t       cpu_addr,
    input  data_t       cpu_wdata,
    input  strb_t       cpu_wstrb,
    input  logic        ram_sel,
    input  logic        ram_we,
    input  logic        flash_sel,
    input  logic        status_sel,
    input  logic        pad_sel,
    input  logic        none_sel,
    input  data_t       ram_rdata,
    input  data_t       flash_rdata,
    input  logic        flash_done,
    input  data_t       io_rdata,
    output logic        ram_cs,
    output logic        ram_we_q,
    output logic [13:0] ram_addr,
    output data_t       ram_wdata,
    output strb_t       ram_wstrb,
    output logic        flash_req,
    output logic [11:0] flash_index,
    output logic        io_wr,
    output strb_t       io_wstrb,
    output data_t       io_wdata,
    output logic        cpu_ready,
    output data_t       cpu_rdata
);
    logic  ack_q;
    logic  busy;
    logic  imm_src;
    logic  flash_sel_r;
    addr_t flash_offset;
    data_t rdata_mux;

    // targets that answer in the same cycle
    assign imm_src = ram_sel || status_sel || pad_sel || none_sel;

    // busy while an ack for this access is in flight
    assign ram_cs    = ram_sel;
    assign ram_we_q  = ram_we && !busy;
    assign ram_addr  = cpu_addr[15:2];
    assign ram_wdata = cpu_wdata;
    assign ram_wstrb = cpu_wstrb;

    assign flash_offset = cpu_addr - FLASH_BASE;
    assign flash_index  = flash_offset[13:2];
    assign flash_req    = flash_sel && !flash_done && !busy;

    assign io_wr    = (status_sel || pad_sel) && (|cpu_wstrb) && !busy;
    assign io_wstrb = cpu_wstrb;
    assign io_wdata = cpu_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q       <= 1'b0;
            flash_sel_r <= 1'b0;
        end else begin
            ack_q       <= (imm_src && !busy) || flash_done;
            flash_sel_r <= flash_sel;
        end
    end

    // flash first, then I/O, then RAM; unmapped reads give zero
    always_comb begin
        if (flash_sel_r) begin
            rdata_mux = flash_rdata;
        end else if (status_sel || pad_sel) begin
            rdata_mux = io_rdata;
        end else if (ram_sel) begin
            rdata_mux = ram_rdata;
        end else begin
            rdata_mux = '0;
        end
    end

    if (READ_DATA_REG) begin : g_rdata_reg
        logic  ready_q;
        data_t rdata_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                ready_q <= 1'b0;
                rdata_q <= '0;
            end else begin
                ready_q <= ack_q;
                rdata_q <= rdata_mux;
            end
        end

        assign busy      = ack_q || ready_q;
        assign cpu_ready = ready_q;
        assign cpu_rdata = rdata_q;
    end else begin : g_rdata_comb
        assign busy      = ack_q;
        assign cpu_ready = ack_q;
        assign cpu_rdata = rdata_mux;
    end

endmodule

/* design/address_decoder.sv */
/*
 * Address decoder for the CPU bus.
 * Turns the current request address into one-hot region selects
 * and a RAM write enable, all combinational.
 */
module address_decoder
    import cpu_bus_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic  cpu_valid,
    input  addr_t cpu_addr,
    input  strb_t cpu_wstrb,
    output logic  ram_sel,
    output logic  ram_we,
    output logic  flash_sel,
    output logic  status_sel,
    output logic  pad_sel,
    output logic  none_sel
);
    // RAM is mirrored through the window below flash in whole copies
    localparam int RAM_BYTES   = RAM_WORDS * 4;
    localparam int RAM_WINDOW  = int'(FLASH_BASE) - int'(RAM_BASE);
    localparam int RAM_SPAN    = (RAM_BYTES >= RAM_WINDOW) ? RAM_WINDOW :
                                 (RAM_WINDOW / RAM_BYTES) * RAM_BYTES;
    localparam int RAM_LIMIT   = int'(RAM_BASE) + RAM_SPAN;
    localparam int FLASH_LIMIT = int'(FLASH_BASE) + FLASH_WORDS * 4;

    region_e region;

    always_comb begin
        if (cpu_addr >= RAM_BASE && 32'(cpu_addr) < RAM_LIMIT) begin
            region = REGION_RAM;
        end else if (cpu_addr >= FLASH_BASE && 32'(cpu_addr) < FLASH_LIMIT) begin
            region = REGION_FLASH;
        end else if (cpu_addr == STATUS_ADDR) begin
            region = REGION_STATUS;
        end else if (cpu_addr == PAD_ADDR) begin
            region = REGION_PAD;
        end else begin
            region = REGION_NONE;
        end
    end

    // no select at all while the bus is idle
    assign ram_sel    = cpu_valid && (region == REGION_RAM);
    assign flash_sel  = cpu_valid && (region == REGION_FLASH);
    assign status_sel = cpu_valid && (region == REGION_STATUS);
    assign pad_sel    = cpu_valid && (region == REGION_PAD);
    assign none_sel   = cpu_valid && (region == REGION_NONE);

    assign ram_we = ram_sel && (|cpu_wstrb);

endmodule

/* design/cpu_bus_pkg.sv */
/*
 * Shared definitions for the CPU memory bus: widths, memory map,
 * region encoding and the flash content rule.
 * Imported by the RTL blocks and by the testbench reference model.
 */
package cpu_bus_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_FLASH,
        REGION_STATUS,
        REGION_PAD,
        REGION_NONE
    } region_e;

    // memory map, byte addresses
    localparam addr_t RAM_BASE    = 16'h0000;
    localparam addr_t FLASH_BASE  = 16'h8000;
    localparam addr_t STATUS_ADDR = 16'hC000;
    localparam addr_t PAD_ADDR    = 16'hC004;

    // flash window is 0x8000 to 0xBFFF
    localparam int FLASH_WORDS = 4096;

    // flash image: fixed tag in the upper half, word index below
    function automatic data_t flash_word(input logic [11:0] index);
        return {16'hF1A5, 4'h0, index};
    endfunction

endpackage
